/* cacheDataArray.sv */
`timescale 1ns/1ps

module cacheDataArray (
    input  logic clk,
    input  logic [lsuPkg::INDEX_W-1:0] ldIndex,
    output logic [lsuPkg::WAYS-1:0][lsuPkg::DATA_W-1:0] ldWords,
    input  logic stWe,
    input  logic [lsuPkg::WAY_W-1:0] stWay,
    input  logic [lsuPkg::INDEX_W-1:0] stIndex,
    input  logic [lsuPkg::DATA_W-1:0] stData,
    input  logic [lsuPkg::MASK_W-1:0] stMask,
    input  logic fillWe,
    input  logic [lsuPkg::WAY_W-1:0] fillWay,
    input  logic [lsuPkg::INDEX_W-1:0] fillIndex,
    input  logic [lsuPkg::DATA_W-1:0] fillData,
    input  logic [lsuPkg::WAY_W-1:0] evictWay,
    input  logic [lsuPkg::INDEX_W-1:0] evictIndex,
    output logic [lsuPkg::DATA_W-1:0] evictData
);
    import lsuPkg::*;

    logic [DATA_W-1:0] mem [WAYS][SETS*LINE_WORDS];

    always_ff @(posedge clk) begin
        // both ways read at once, the load pipe selects after the tag compare
        for (int w = 0; w < WAYS; w++) begin
            ldWords[w] <= mem[w][ldIndex];
        end
        for (int b = 0; b < MASK_W; b++) begin
            if (stWe && stMask[b]) begin
                mem[stWay][stIndex][8*b +: 8] <= stData[8*b +: 8];
            end
        end
        if (fillWe) begin
            mem[fillWay][fillIndex] <= fillData;
        end
    end

    assign evictData = mem[evictWay][evictIndex];

    // stores only write with the FSM idle, fills only while it is busy
    singleWritePort: assert property (@(posedge clk) stWe |-> !fillWe);

endmodule

/* cacheTagTable.sv */
`timescale 1ns/1ps

module cacheTagTable (
    input  logic clk,
    input  logic rst,
    input  logic [lsuPkg::SET_W-1:0] ldSet,
    input  logic [lsuPkg::SET_W-1:0] stSet,
    input  logic [lsuPkg::SET_W-1:0] fsmSet,
    output lsuPkg::tagEntry_t [lsuPkg::WAYS-1:0] ldEntries,
    output lsuPkg::tagEntry_t [lsuPkg::WAYS-1:0] stEntries,
    output lsuPkg::tagEntry_t [lsuPkg::WAYS-1:0] fsmEntries,
    input  logic tagWe,
    input  logic [lsuPkg::WAY_W-1:0] tagWay,
    input  lsuPkg::tagEntry_t tagWdata,
    input  logic [lsuPkg::SET_W-1:0] dirtySet,
    input  logic [lsuPkg::WAY_W-1:0] dirtyWay,
    input  logic dirtyWe
);
    import lsuPkg::*;

    tagEntry_t [WAYS-1:0] entries [SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                entries[s] <= '0;
            end
        end else begin
            if (tagWe) begin
                entries[fsmSet][tagWay] <= tagWdata;
            end
            if (dirtyWe) begin
                entries[dirtySet][dirtyWay].dirty <= 1'b1;
            end
        end
    end

    // pipelines see the set one cycle after the request is accepted
    always_ff @(posedge clk) begin
        ldEntries <= entries[ldSet];
        stEntries <= entries[stSet];
    end

    // the FSM picks its victim in the cycle a store may dirty that very line,
    // so a dirty update in flight is forwarded
    always_comb begin
        fsmEntries = entries[fsmSet];
        if (dirtyWe && dirtySet == fsmSet) begin
            fsmEntries[dirtyWay].dirty = 1'b1;
        end
    end

    // fill or invalidate never lands on the entry a store is marking dirty
    tagDirtyDisjoint: assert property (@(posedge clk) disable iff (rst)
        tagWe && dirtyWe |-> fsmSet != dirtySet || tagWay != dirtyWay);

endmodule

/* loadPipe.sv */
`timescale 1ns/1ps

module loadPipe (
    input  logic clk,
    input  logic rst,
    input  lsuPkg::ldReq_t ldReq,
    input  logic accept,
    input  lsuPkg::tagEntry_t [lsuPkg::WAYS-1:0] ldEntries,
    input  logic [lsuPkg::WAYS-1:0][lsuPkg::DATA_W-1:0] ldWords,
    input  logic storeInFlight,
    input  logic fsmIdle,
    output lsuPkg::ldRes_t ldRes,
    output lsuPkg::missReq_t loadMiss
);
    import lsuPkg::*;

    ldReq_t s1Req;
    ldReq_t s2Req;
    logic [WAYS-1:0] hitVec;
    logic [DATA_W-1:0] hitWord;
    logic s1StoreSeen;
    logic s2StoreSeen;
    logic s2Hit;
    logic [DATA_W-1:0] s2Word;
    logic [1:0] byteOff;
    logic [7:0] selByte;
    logic [15:0] selHalf;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Req.valid <= 1'b0;
            s2Req.valid <= 1'b0;
        end else begin
            s1Req <= ldReq;
            s1Req.valid <= accept;
            s2Req <= s1Req;
        end
    end

    // stage 1: tags and words arrive from the registered reads
    always_comb begin
        hitVec = wayHits(ldEntries, s1Req.addr);
        hitWord = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hitVec[w]) begin
                hitWord = ldWords[w];
            end
        end
    end

    // a store written while the load is in flight can be missing from the
    // word read at acceptance, so any store seen along the way fails it
    always_ff @(posedge clk) begin
        s1StoreSeen <= storeInFlight;
        s2StoreSeen <= s1StoreSeen || storeInFlight;
        s2Hit <= |hitVec;
        s2Word <= hitWord;
    end

    // stage 2: extract and extend the addressed part
    assign byteOff = s2Req.addr[1:0];
    assign selByte = s2Word[8*byteOff +: 8];
    assign selHalf = s2Word[16*byteOff[1] +: 16];

    always_comb begin
        ldRes.valid = s2Req.valid;
        ldRes.fail = !s2Hit || !fsmIdle || s2StoreSeen || storeInFlight;
        ldRes.id = s2Req.id;
        case (s2Req.size)
            BYTE: ldRes.result = {{(DATA_W-8){s2Req.signExtend && selByte[7]}}, selByte};
            HALF: ldRes.result = {{(DATA_W-16){s2Req.signExtend && selHalf[15]}}, selHalf};
            default: ldRes.result = s2Word;
        endcase
        loadMiss.valid = s2Req.valid && !s2Hit;
        loadMiss.lineAddr = addrLine(s2Req.addr);
    end

    // a line is never resident in two ways
    singleWayHit: assert property (@(posedge clk) disable iff (rst)
        s1Req.valid |-> $onehot0(hitVec));

endmodule

/* loadStoreUnit.f */
+incdir+.
lsuPkg.sv
cacheTagTable.sv
cacheDataArray.sv
loadPipe.sv
storePipe.sv
transferCounter.sv
transferFsm.sv
loadStoreUnit.sv
tbLoadStoreUnit.sv

/* loadStoreUnit.sv */
`timescale 1ns/1ps

module loadStoreUnit (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  lsuPkg::ldReq_t ldReq,
    output logic ldStall,
    output lsuPkg::ldRes_t ldRes,
    input  lsuPkg::stReq_t stReq,
    output logic stStall,
    output lsuPkg::stAck_t stAck,
    output lsuPkg::memReq_t memReq,
    input  lsuPkg::memRsp_t memRsp,
    output logic busy
);
    import lsuPkg::*;

    logic ldAccept;
    logic stAccept;
    logic ldStage1;
    logic storeInFlight;
    logic fsmIdle;
    logic flushPending;
    logic pipesEmpty;
    tagEntry_t [WAYS-1:0] ldEntries;
    tagEntry_t [WAYS-1:0] stEntries;
    tagEntry_t [WAYS-1:0] fsmEntries;
    logic [SET_W-1:0] fsmSet;
    logic tagWe;
    logic [WAY_W-1:0] tagWay;
    tagEntry_t tagWdata;
    logic dirtyWe;
    logic [SET_W-1:0] dirtySet;
    logic [WAY_W-1:0] dirtyWay;
    logic [WAYS-1:0][DATA_W-1:0] ldWords;
    logic stWe;
    logic [WAY_W-1:0] stWay;
    logic [INDEX_W-1:0] stIndex;
    logic [DATA_W-1:0] stData;
    logic [MASK_W-1:0] stMask;
    logic fillWe;
    logic [WAY_W-1:0] fillWay;
    logic [INDEX_W-1:0] fillIndex;
    logic [DATA_W-1:0] fillData;
    logic [WAY_W-1:0] evictWay;
    logic [INDEX_W-1:0] evictIndex;
    logic [DATA_W-1:0] evictData;
    missReq_t loadMiss;
    missReq_t storeMiss;

    // new work waits for a running transfer or a pending flush
    assign ldStall = !fsmIdle || flushPending;
    // single write port, one store in the pipe at a time
    assign stStall = ldStall || storeInFlight;
    assign ldAccept = ldReq.valid && !ldStall;
    assign stAccept = stReq.valid && !stStall;

    // load in stage 1; stage 2 shows up as ldRes.valid
    always_ff @(posedge clk) begin
        if (rst) begin
            ldStage1 <= 1'b0;
        end else begin
            ldStage1 <= ldAccept;
        end
    end

    assign pipesEmpty = !ldStage1 && !ldRes.valid && !storeInFlight;
    assign busy = !pipesEmpty || flushPending || !fsmIdle;

    cacheTagTable u_tagTable (
        .clk(clk), .rst(rst),
        .ldSet(addrSet(ldReq.addr)), .stSet(addrSet(stReq.addr)), .fsmSet(fsmSet),
        .ldEntries(ldEntries), .stEntries(stEntries), .fsmEntries(fsmEntries),
        .tagWe(tagWe), .tagWay(tagWay), .tagWdata(tagWdata),
        .dirtySet(dirtySet), .dirtyWay(dirtyWay), .dirtyWe(dirtyWe)
    );

    cacheDataArray u_dataArray (
        .clk(clk),
        .ldIndex(addrIndex(ldReq.addr)), .ldWords(ldWords),
        .stWe(stWe), .stWay(stWay), .stIndex(stIndex), .stData(stData), .stMask(stMask),
        .fillWe(fillWe), .fillWay(fillWay), .fillIndex(fillIndex), .fillData(fillData),
        .evictWay(evictWay), .evictIndex(evictIndex), .evictData(evictData)
    );

    loadPipe u_loadPipe (
        .clk(clk), .rst(rst),
        .ldReq(ldReq), .accept(ldAccept),
        .ldEntries(ldEntries), .ldWords(ldWords),
        .storeInFlight(storeInFlight), .fsmIdle(fsmIdle),
        .ldRes(ldRes), .loadMiss(loadMiss)
    );

    storePipe u_storePipe (
        .clk(clk), .rst(rst),
        .stReq(stReq), .accept(stAccept),
        .stEntries(stEntries), .fsmIdle(fsmIdle),
        .stAck(stAck), .storeInFlight(storeInFlight),
        .stWe(stWe), .stWay(stWay), .stIndex(stIndex), .stData(stData), .stMask(stMask),
        .dirtyWe(dirtyWe), .dirtySet(dirtySet), .dirtyWay(dirtyWay),
        .storeMiss(storeMiss)
    );

    transferFsm u_transferFsm (
        .clk(clk), .rst(rst),
        .flush(flush), .pipesEmpty(pipesEmpty),
        .loadMiss(loadMiss), .storeMiss(storeMiss),
        .fsmEntries(fsmEntries), .fsmSet(fsmSet),
        .tagWe(tagWe), .tagWay(tagWay), .tagWdata(tagWdata),
        .evictData(evictData), .evictWay(evictWay), .evictIndex(evictIndex),
        .fillWe(fillWe), .fillWay(fillWay), .fillIndex(fillIndex), .fillData(fillData),
        .memReq(memReq), .memRsp(memRsp),
        .fsmIdle(fsmIdle), .flushPending(flushPending)
    );

endmodule

/* lsuPkg.sv */
package lsuPkg;

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int WAYS = 2;
    localparam int SETS = 8;
    localparam int LINE_WORDS = 4;
    localparam int ID_W = 4;

    localparam int WAY_W = $clog2(WAYS);
    localparam int SET_W = $clog2(SETS);
    localparam int BEAT_W = $clog2(LINE_WORDS);
    // address is {tag, set, beat, byte offset}
    localparam int TAG_W = ADDR_W - SET_W - BEAT_W - 2;
    localparam int LINE_W = TAG_W + SET_W;
    localparam int WADDR_W = ADDR_W - 2;
    localparam int INDEX_W = SET_W + BEAT_W;
    localparam int MASK_W = DATA_W / 8;

    typedef enum logic [1:0] {BYTE, HALF, WORD} ldSize_t;

    typedef enum logic [2:0] {
        IDLE, EVICT, FILL, FLUSH_READ, FLUSH_CHECK, FLUSH_EVICT
    } lsuState_t;

    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        ldSize_t size;
        logic signExtend;
        logic [ID_W-1:0] id;
    } ldReq_t;

    typedef struct packed {
        logic valid;
        logic fail;
        logic [ID_W-1:0] id;
        logic [DATA_W-1:0] result;
    } ldRes_t;

    typedef struct packed {
        logic valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [MASK_W-1:0] wmask;
        logic [ID_W-1:0] id;
    } stReq_t;

    typedef struct packed {
        logic valid;
        logic fail;
        logic [ID_W-1:0] id;
    } stAck_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        logic [TAG_W-1:0] tag;
    } tagEntry_t;

    typedef struct packed {
        logic valid;
        logic [LINE_W-1:0] lineAddr;
    } missReq_t;

    typedef struct packed {
        logic valid;
        logic write;
        logic [WADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic ack;
        logic [DATA_W-1:0] rdata;
    } memRsp_t;

    function automatic logic [SET_W-1:0] addrSet(logic [ADDR_W-1:0] addr);
        return addr[BEAT_W+2 +: SET_W];
    endfunction

    // word slot of the address inside one way of the data array
    function automatic logic [INDEX_W-1:0] addrIndex(logic [ADDR_W-1:0] addr);
        return addr[2 +: INDEX_W];
    endfunction

    function automatic logic [LINE_W-1:0] addrLine(logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: LINE_W];
    endfunction

    function automatic logic [WAYS-1:0] wayHits(tagEntry_t [WAYS-1:0] entries,
                                                logic [ADDR_W-1:0] addr);
        logic [WAYS-1:0] hits;
        for (int w = 0; w < WAYS; w++) begin
            hits[w] = entries[w].valid && entries[w].tag == addr[ADDR_W-1 -: TAG_W];
        end
        return hits;
    endfunction

endpackage

/* storePipe.sv */
`timescale 1ns/1ps

module storePipe (
    input  logic clk,
    input  logic rst,
    input  lsuPkg::stReq_t stReq,
    input  logic accept,
    input  lsuPkg::tagEntry_t [lsuPkg::WAYS-1:0] stEntries,
    input  logic fsmIdle,
    output lsuPkg::stAck_t stAck,
    output logic storeInFlight,
    output logic stWe,
    output logic [lsuPkg::WAY_W-1:0] stWay,
    output logic [lsuPkg::INDEX_W-1:0] stIndex,
    output logic [lsuPkg::DATA_W-1:0] stData,
    output logic [lsuPkg::MASK_W-1:0] stMask,
    output logic dirtyWe,
    output logic [lsuPkg::SET_W-1:0] dirtySet,
    output logic [lsuPkg::WAY_W-1:0] dirtyWay,
    output lsuPkg::missReq_t storeMiss
);
    import lsuPkg::*;

    stReq_t s1Req;
    stReq_t s2Req;
    logic [WAYS-1:0] hitVec;
    logic [WAY_W-1:0] hitWay;
    logic s2Hit;
    logic [WAY_W-1:0] s2Way;
    logic doWrite;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Req.valid <= 1'b0;
            s2Req.valid <= 1'b0;
        end else begin
            s1Req <= stReq;
            s1Req.valid <= accept;
            s2Req <= s1Req;
        end
    end

    always_comb begin
        hitVec = wayHits(stEntries, s1Req.addr);
        hitWay = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hitVec[w]) begin
                hitWay = WAY_W'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        s2Hit <= |hitVec;
        s2Way <= hitWay;
    end

    assign storeInFlight = s1Req.valid || s2Req.valid;

    // stage 2 writes only on a hit while no transfer is running
    assign doWrite = s2Req.valid && s2Hit && fsmIdle;

    always_comb begin
        stAck.valid = s2Req.valid;
        stAck.fail = !s2Hit || !fsmIdle;
        stAck.id = s2Req.id;
        stWe = doWrite;
        stWay = s2Way;
        stIndex = addrIndex(s2Req.addr);
        stData = s2Req.data;
        stMask = s2Req.wmask;
        dirtyWe = doWrite;
        dirtySet = addrSet(s2Req.addr);
        dirtyWay = s2Way;
        storeMiss.valid = s2Req.valid && !s2Hit;
        storeMiss.lineAddr = addrLine(s2Req.addr);
    end

endmodule

/* tbLsuModel.svh */
`ifndef TB_LSU_MODEL_SVH
`define TB_LSU_MODEL_SVH

// reference copy of the external memory that only successful stores change
logic [DATA_W-1:0] model [MEM_WORDS];

function automatic logic [MEM_AW-1:0] wordOf(logic [ADDR_W-1:0] byteAddr);
    return byteAddr[2 +: MEM_AW];
endfunction

// value a load should return when it succeeds
function automatic logic [DATA_W-1:0] expectedLoad(logic [ADDR_W-1:0] byteAddr,
                                                   ldSize_t size, logic sext);
    logic [DATA_W-1:0] word;
    logic [7:0] lane8;
    logic [15:0] lane16;
    word = model[wordOf(byteAddr)];
    // the addressed byte or half starts at the byte offset within the word
    lane8 = 8'(word >> (8 * byteAddr[1:0]));
    lane16 = 16'(word >> (8 * byteAddr[1:0]));
    case (size)
        BYTE: return sext ? DATA_W'($signed(lane8)) : DATA_W'(lane8);
        HALF: return sext ? DATA_W'($signed(lane16)) : DATA_W'(lane16);
        default: return word;
    endcase
endfunction

function automatic void applyStore(logic [ADDR_W-1:0] byteAddr, logic [DATA_W-1:0] data,
                                   logic [MASK_W-1:0] mask);
    for (int b = 0; b < MASK_W; b++) begin
        if (mask[b]) begin
            model[wordOf(byteAddr)][8*b +: 8] = data[8*b +: 8];
        end
    end
endfunction

task automatic checkEq(input string name, input logic [DATA_W-1:0] got,
                       input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
        abortRun($sformatf("Error at %0t ns: %s is 0x%h, expected 0x%h",
                           $time, name, got, exp));
    end
endtask

`endif

/* tbLoadStoreUnit.sv */
`timescale 1ns/1ps

module tbLoadStoreUnit;
    import lsuPkg::*;

    localparam int MEM_AW = 8;
    localparam int MEM_WORDS = 1 << MEM_AW;
    localparam int NUM_WORD_LOADS = 32;
    localparam int NUM_SIZED_LOADS = 32;
    localparam int NUM_STORES = 24;
    localparam int NUM_BURST = 48;
    // a store round is the store, a load back, a random load and a late reload;
    // the flush walk is counted as eight operations
    localparam int TOTAL_OPS = 1 + NUM_WORD_LOADS + NUM_SIZED_LOADS + 4 * NUM_STORES
                             + NUM_BURST + 8 + 1;
    localparam int CYCLE_LIMIT = TOTAL_OPS * 60;

    logic clk = 1'b0;
    logic rst;
    logic flush;
    ldReq_t ldReq;
    logic ldStall;
    ldRes_t ldRes;
    stReq_t stReq;
    logic stStall;
    stAck_t stAck;
    memReq_t memReq;
    memRsp_t memRsp = '0;
    logic busy;

    logic [DATA_W-1:0] extMem [MEM_WORDS];
    int unsigned ackWait = 0;
    int cycleCount = 0;
    logic [ID_W-1:0] ldId = '0;
    logic [ID_W-1:0] stId = '0;
    // accepted operations still waiting for their response in acceptance order
    ldReq_t ldPend [$];
    int ldPendCyc [$];
    stReq_t stPend [$];
    int stPendCyc [$];
    ldReq_t ldHead;
    stReq_t stHead;
    int headCyc;
    logic [ADDR_W-1:0] storedAddrs [$];

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    `include "tbLsuModel.svh"

    loadStoreUnit u_loadStoreUnit (
        .clk(clk), .rst(rst), .flush(flush),
        .ldReq(ldReq), .ldStall(ldStall), .ldRes(ldRes),
        .stReq(stReq), .stStall(stStall), .stAck(stAck),
        .memReq(memReq), .memRsp(memRsp), .busy(busy)
    );

    always #2 clk = ~clk;

    // external memory acks one word after 0 to 3 idle cycles
    always @(posedge clk) begin
        if (rst) begin
            memRsp.ack <= 1'b0;
        end else if (memRsp.ack) begin
            memRsp.ack <= 1'b0;
            ackWait <= $urandom_range(0, 3);
        end else if (memReq.valid) begin
            if (memReq.addr >= WADDR_W'(MEM_WORDS)) begin
                abortRun("memory request outside the external memory");
            end
            if (ackWait == 0) begin
                memRsp.ack <= 1'b1;
                memRsp.rdata <= extMem[memReq.addr[MEM_AW-1:0]];
                if (memReq.write) begin
                    extMem[memReq.addr[MEM_AW-1:0]] <= memReq.wdata;
                end
            end else begin
                ackWait <= ackWait - 1;
            end
        end
    end

    task automatic trackLoads();
        if (ldPend.size() != 0 && ldPendCyc[0] + 2 == cycleCount && !ldRes.valid) begin
            abortRun("an accepted load got no response two cycles later");
        end
        if (ldRes.valid) begin
            if (ldPend.size() == 0) begin
                abortRun("load response with no accepted load outstanding");
            end
            ldHead = ldPend.pop_front();
            headCyc = ldPendCyc.pop_front();
            checkEq("ldRes.id", DATA_W'(ldRes.id), DATA_W'(ldHead.id));
            checkEq("load latency", DATA_W'(cycleCount - headCyc), 2);
            if (!ldRes.fail) begin
                checkEq("ldRes.result", ldRes.result,
                        expectedLoad(ldHead.addr, ldHead.size, ldHead.signExtend));
            end
        end
        if (ldReq.valid && !ldStall) begin
            ldPend.push_back(ldReq);
            ldPendCyc.push_back(cycleCount);
        end
    endtask

    task automatic trackStores();
        if (stPend.size() != 0 && stPendCyc[0] + 2 == cycleCount && !stAck.valid) begin
            abortRun("an accepted store got no acknowledge two cycles later");
        end
        if (stAck.valid) begin
            if (stPend.size() == 0) begin
                abortRun("store acknowledge with no accepted store outstanding");
            end
            stHead = stPend.pop_front();
            headCyc = stPendCyc.pop_front();
            checkEq("stAck.id", DATA_W'(stAck.id), DATA_W'(stHead.id));
            checkEq("store latency", DATA_W'(cycleCount - headCyc), 2);
            if (!stAck.fail) begin
                applyStore(stHead.addr, stHead.data, stHead.wmask);
            end
        end
        if (stReq.valid && !stStall) begin
            stPend.push_back(stReq);
            stPendCyc.push_back(cycleCount);
        end
    endtask

    // loads are checked before stores so a store acked now only affects later loads
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            abortRun("run did not finish within its cycle limit");
        end
        if (!rst) begin
            trackLoads();
            trackStores();
        end
    end

    function automatic logic [ADDR_W-1:0] randomAddr(ldSize_t size);
        logic [ADDR_W-1:0] a;
        a = ADDR_W'($urandom_range(0, MEM_WORDS * 4 - 1));
        if (size == WORD) begin
            a[1:0] = 2'b00;
        end else if (size == HALF) begin
            a[0] = 1'b0;
        end
        return a;
    endfunction

    function automatic ldReq_t randomLoad(logic [ID_W-1:0] id);
        ldReq_t r;
        r.valid = 1'b1;
        r.size = ldSize_t'(2'($urandom_range(0, 2)));
        r.addr = randomAddr(r.size);
        r.signExtend = 1'($urandom_range(0, 1));
        r.id = id;
        return r;
    endfunction

    task automatic loadUntilHit(input logic [ADDR_W-1:0] byteAddr, input ldSize_t size,
                                input logic sext);
        logic hit;
        hit = 1'b0;
        while (!hit) begin
            ldReq <= '{valid: 1'b1, addr: byteAddr, size: size, signExtend: sext, id: ldId};
            ldId = ldId + 1'b1;
            do @(posedge clk); while (ldStall);
            ldReq.valid <= 1'b0;
            do @(posedge clk); while (!ldRes.valid);
            hit = !ldRes.fail;
        end
    endtask

    task automatic storeUntilHit(input logic [ADDR_W-1:0] byteAddr,
                                 input logic [DATA_W-1:0] data, input logic [MASK_W-1:0] mask);
        logic done;
        done = 1'b0;
        while (!done) begin
            stReq <= '{valid: 1'b1, addr: byteAddr, data: data, wmask: mask, id: stId};
            stId = stId + 1'b1;
            do @(posedge clk); while (stStall);
            stReq.valid <= 1'b0;
            do @(posedge clk); while (!stAck.valid);
            done = !stAck.fail;
        end
    endtask

    // issues a new load in every cycle without stall and never retries a failed one
    task automatic loadBurst(input int count);
        int sent;
        sent = 0;
        ldReq <= randomLoad(ldId);
        ldId = ldId + 1'b1;
        while (sent < count) begin
            @(posedge clk);
            if (!ldStall) begin
                sent++;
                if (sent < count) begin
                    ldReq <= randomLoad(ldId);
                    ldId = ldId + 1'b1;
                end else begin
                    ldReq.valid <= 1'b0;
                end
            end
        end
        do @(posedge clk); while (busy);
    endtask

    initial begin
        logic [ADDR_W-1:0] addr;
        ldSize_t size;
        void'($urandom(32'hf0c6));
        for (int i = 0; i < MEM_WORDS; i++) begin
            extMem[i] = $urandom();
            model[i] = extMem[i];
        end
        rst = 1'b1;
        flush = 1'b0;
        ldReq = '0;
        stReq = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        checkEq("ldRes.valid", DATA_W'(ldRes.valid), 0);
        checkEq("stAck.valid", DATA_W'(stAck.valid), 0);
        checkEq("memReq.valid", DATA_W'(memReq.valid), 0);
        checkEq("ldStall", DATA_W'(ldStall), 0);
        checkEq("stStall", DATA_W'(stStall), 0);
        checkEq("busy", DATA_W'(busy), 0);

        // memory is four times the cache, so most first tries miss
        for (int i = 0; i < NUM_WORD_LOADS; i++) begin
            loadUntilHit(randomAddr(WORD), WORD, 1'b0);
        end
        for (int i = 0; i < NUM_SIZED_LOADS; i++) begin
            size = (i % 2 == 0) ? BYTE : HALF;
            loadUntilHit(randomAddr(size), size, 1'($urandom_range(0, 1)));
        end

        for (int i = 0; i < NUM_STORES; i++) begin
            addr = randomAddr(WORD);
            storeUntilHit(addr, $urandom(), MASK_W'($urandom_range(0, 15)));
            storedAddrs.push_back(addr);
            loadUntilHit(addr, WORD, 1'b0);
            loadUntilHit(randomAddr(WORD), WORD, 1'b0);
        end
        // many stored lines are written back by now
        foreach (storedAddrs[i]) begin
            loadUntilHit(storedAddrs[i], WORD, 1'b0);
        end

        loadBurst(NUM_BURST);

        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        do @(posedge clk); while (busy);
        for (int i = 0; i < MEM_WORDS; i++) begin
            checkEq($sformatf("extMem[%0d]", i), extMem[i], model[i]);
        end
        loadUntilHit(randomAddr(WORD), WORD, 1'b0);
        do @(posedge clk); while (busy);

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* transferCounter.sv */
`timescale 1ns/1ps

module transferCounter (
    input  logic clk,
    input  logic rst,
    input  logic clearBeat,
    input  logic beatAck,
    output logic [lsuPkg::BEAT_W-1:0] beatIdx,
    output logic lastBeat,
    input  logic clearFlush,
    input  logic flushStep,
    output logic [lsuPkg::SET_W-1:0] flushSet,
    output logic [lsuPkg::WAY_W-1:0] flushWay,
    output logic flushDone
);
    import lsuPkg::*;

    // beat count wraps to zero after the last word of a line
    always_ff @(posedge clk) begin
        if (rst || clearBeat) begin
            beatIdx <= '0;
        end else if (beatAck) begin
            beatIdx <= beatIdx + 1'b1;
        end
    end

    assign lastBeat = beatIdx == BEAT_W'(LINE_WORDS - 1);

    // way is the low part, so all ways of a set go before the next set
    always_ff @(posedge clk) begin
        if (rst || clearFlush) begin
            {flushSet, flushWay} <= '0;
            flushDone <= 1'b0;
        end else if (flushStep) begin
            {flushSet, flushWay} <= {flushSet, flushWay} + 1'b1;
            if (&{flushSet, flushWay}) begin
                flushDone <= 1'b1;
            end
        end
    end

endmodule

/* transferFsm.sv */
`timescale 1ns/1ps

module transferFsm (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic pipesEmpty,
    input  lsuPkg::missReq_t loadMiss,
    input  lsuPkg::missReq_t storeMiss,
    input  lsuPkg::tagEntry_t [lsuPkg::WAYS-1:0] fsmEntries,
    output logic [lsuPkg::SET_W-1:0] fsmSet,
    output logic tagWe,
    output logic [lsuPkg::WAY_W-1:0] tagWay,
    output lsuPkg::tagEntry_t tagWdata,
    input  logic [lsuPkg::DATA_W-1:0] evictData,
    output logic [lsuPkg::WAY_W-1:0] evictWay,
    output logic [lsuPkg::INDEX_W-1:0] evictIndex,
    output logic fillWe,
    output logic [lsuPkg::WAY_W-1:0] fillWay,
    output logic [lsuPkg::INDEX_W-1:0] fillIndex,
    output logic [lsuPkg::DATA_W-1:0] fillData,
    output lsuPkg::memReq_t memReq,
    input  lsuPkg::memRsp_t memRsp,
    output logic fsmIdle,
    output logic flushPending
);
    import lsuPkg::*;

    lsuState_t state;
    missReq_t miss;
    tagEntry_t victimEntry;
    logic [LINE_W-1:0] curLine;
    logic [TAG_W-1:0] victimTag;
    logic victimDirty;
    logic [WAY_W-1:0] victimWay;
    logic [WAY_W-1:0] rrWay;
    logic [BEAT_W-1:0] beatIdx;
    logic lastBeat;
    logic beatAck;
    logic lineDone;
    logic flushStep;
    logic flushDone;
    logic [SET_W-1:0] flushSet;
    logic [WAY_W-1:0] flushWay;

    // the load's miss wins when both pipes miss together
    assign miss = loadMiss.valid ? loadMiss : storeMiss;

    always_comb begin
        case (state)
            IDLE: fsmSet = miss.lineAddr[SET_W-1:0];
            EVICT, FILL: fsmSet = curLine[SET_W-1:0];
            default: fsmSet = flushSet;
        endcase
    end

    assign victimEntry = fsmEntries[(state == IDLE) ? rrWay : flushWay];
    assign beatAck = memReq.valid && memRsp.ack;
    assign lineDone = beatAck && lastBeat;
    assign flushStep = (state == FLUSH_CHECK && !victimDirty)
                    || (state == FLUSH_EVICT && lineDone);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            rrWay <= '0;
            flushPending <= 1'b0;
        end else begin
            if (flush) begin
                flushPending <= 1'b1;
            end
            case (state)
                IDLE: begin
                    if (miss.valid) begin
                        rrWay <= rrWay + 1'b1;
                        // a clean or empty victim goes straight to the fill
                        state <= (victimEntry.valid && victimEntry.dirty) ? EVICT : FILL;
                    end else if (flushPending && pipesEmpty) begin
                        flushPending <= 1'b0;
                        state <= FLUSH_READ;
                    end
                end
                EVICT: state <= lineDone ? FILL : EVICT;
                FILL: state <= lineDone ? IDLE : FILL;
                FLUSH_READ: state <= flushDone ? IDLE : FLUSH_CHECK;
                FLUSH_CHECK: state <= victimDirty ? FLUSH_EVICT : FLUSH_READ;
                FLUSH_EVICT: state <= lineDone ? FLUSH_READ : FLUSH_EVICT;
                default: state <= IDLE;
            endcase
        end
    end

    // victim details, captured where the entry is looked at
    always_ff @(posedge clk) begin
        if (state == IDLE) begin
            curLine <= miss.lineAddr;
            victimWay <= rrWay;
            victimTag <= victimEntry.tag;
        end else if (state == FLUSH_READ) begin
            victimWay <= flushWay;
            victimTag <= victimEntry.tag;
            victimDirty <= victimEntry.valid && victimEntry.dirty;
        end
    end

    transferCounter u_transferCounter (
        .clk(clk), .rst(rst),
        .clearBeat(state == IDLE || state == FLUSH_CHECK), .beatAck(beatAck),
        .beatIdx(beatIdx), .lastBeat(lastBeat),
        .clearFlush(state == IDLE), .flushStep(flushStep),
        .flushSet(flushSet), .flushWay(flushWay), .flushDone(flushDone)
    );

    always_comb begin
        // new line lands clean; flush clears the entry
        tagWe = flushStep || (state == FILL && lineDone);
        tagWay = victimWay;
        tagWdata.valid = state == FILL;
        tagWdata.dirty = 1'b0;
        tagWdata.tag = curLine[LINE_W-1 -: TAG_W];

        evictWay = victimWay;
        evictIndex = {fsmSet, beatIdx};
        fillWe = state == FILL && beatAck;
        fillWay = victimWay;
        fillIndex = {fsmSet, beatIdx};
        fillData = memRsp.rdata;

        memReq.valid = state == EVICT || state == FILL || state == FLUSH_EVICT;
        memReq.write = state != FILL;
        memReq.addr = (state == FILL) ? {curLine, beatIdx} : {victimTag, fsmSet, beatIdx};
        memReq.wdata = memReq.write ? evictData : '0;
    end

    assign fsmIdle = state == IDLE;

    // request is held unchanged until the memory takes the word
    memReqHeld: assert property (@(posedge clk) disable iff (rst)
        memReq.valid && !memRsp.ack |=> $stable(memReq));

endmodule
